// File: project.f
+incdir+hdl
+incdir+sim
hdl/rv_isa_pkg.sv
hdl/urom_cw_pkg.sv
hdl/urom_field_decoder.sv
hdl/urom_table.sv
hdl/urom_decode_top.sv
sim/urom_decode_tb.sv

// File: sim/urom_vectors.svh
`ifndef UROM_VECTORS_SVH
`define UROM_VECTORS_SVH

// Columns: test number, instruction word, expected invalid_o, expected cw_o

// Single control-word fields, placed at their bit positions in cw_o
localparam logic [32:0] CW_SRC_RS12   = 33'h1 << 31;
localparam logic [32:0] CW_SRC_NONE   = 33'h2 << 31;
localparam logic [32:0] CW_S1_PC      = 33'h1 << 29;
localparam logic [32:0] CW_S2_IMM12   = 33'h1 << 27;
localparam logic [32:0] CW_S2_IMM20   = 33'h2 << 27;
localparam logic [32:0] CW_S2_UPPER   = 33'h3 << 27;
localparam logic [32:0] CW_NOT_SEXT   = 33'h1 << 26;
localparam logic [32:0] CW_CSR_IMM    = 33'h1 << 25;
localparam logic [32:0] CW_ALU_ADD    = 33'h1 << 24;
localparam logic [32:0] CW_ALU_SUB    = 33'h1 << 23;
localparam logic [32:0] CW_AND        = 33'h1 << 21;
localparam logic [32:0] CW_OR         = 33'h2 << 21;
localparam logic [32:0] CW_XOR        = 33'h3 << 21;
localparam logic [32:0] CW_UNSIGNED   = 33'h1 << 20;
localparam logic [32:0] CW_SHIFT_LL   = 33'h1 << 18;
localparam logic [32:0] CW_SHIFT_RL   = 33'h2 << 18;
localparam logic [32:0] CW_SHIFT_RA   = 33'h3 << 18;
localparam logic [32:0] CW_COND_NEG   = 33'h1 << 16;
localparam logic [32:0] CW_COND_ZERO  = 33'h2 << 16;
localparam logic [32:0] CW_COND_INV   = 33'h1 << 15;
localparam logic [32:0] CW_SLT        = 33'h1 << 14;
localparam logic [32:0] CW_ADD_PC     = 33'h1 << 13;
localparam logic [32:0] CW_BJU_BRANCH = 33'h1 << 11;
localparam logic [32:0] CW_BJU_JAL    = 33'h2 << 11;
localparam logic [32:0] CW_BJU_JALR   = 33'h3 << 11;
localparam logic [32:0] CW_REG_WR     = 33'h1 << 10;
localparam logic [32:0] CW_MEM_STORE  = 33'h1 << 9;
localparam logic [32:0] CW_SIZE_HALF  = 33'h1 << 7;
localparam logic [32:0] CW_SIZE_WORD  = 33'h2 << 7;
localparam logic [32:0] CW_MEM_EN     = 33'h1 << 6;
localparam logic [32:0] CW_CSR_EN     = 33'h1 << 5;
localparam logic [32:0] CW_OP_RW      = 33'h7 << 2;
localparam logic [32:0] CW_OP_RS      = 33'h5 << 2;
localparam logic [32:0] CW_OP_RC      = 33'h6 << 2;
localparam logic [32:0] CW_ECALL      = 33'h1;
localparam logic [32:0] CW_MRET       = 33'h2;

// Fields shared by a whole instruction group
localparam logic [32:0] CW_LOAD   = CW_S2_IMM12 | CW_ALU_ADD | CW_REG_WR | CW_MEM_EN;
localparam logic [32:0] CW_STORE  = CW_SRC_RS12 | CW_MEM_STORE | CW_MEM_EN;
localparam logic [32:0] CW_OPIMM  = CW_S2_IMM12 | CW_REG_WR;
localparam logic [32:0] CW_OPREG  = CW_SRC_RS12 | CW_REG_WR;
localparam logic [32:0] CW_BRANCH = CW_SRC_RS12 | CW_BJU_BRANCH;
localparam logic [32:0] CW_CSR    = CW_CSR_EN | CW_S2_IMM12 | CW_REG_WR;
localparam logic [32:0] CW_SLTU   = CW_COND_NEG | CW_UNSIGNED | CW_SLT | CW_NOT_SEXT;

typedef struct packed {
	logic [2:0]              test;
	logic [`URM_INSTR_W-1:0] instr;
	logic                    inval;
	logic [32:0]             cw;
} vector_t;

localparam int NUM_ROWS = 52;

vector_t vectors [NUM_ROWS] = '{
	'{3'd3, 32'h00010083, 1'b0, CW_LOAD},                              // LB
	'{3'd3, 32'h00011083, 1'b0, CW_LOAD | CW_SIZE_HALF},               // LH
	'{3'd3, 32'h00012083, 1'b0, CW_LOAD | CW_SIZE_WORD},               // LW
	'{3'd3, 32'h00014083, 1'b0, CW_LOAD | CW_NOT_SEXT},                // LBU
	'{3'd3, 32'h00015083, 1'b0, CW_LOAD | CW_SIZE_HALF | CW_NOT_SEXT}, // LHU
	'{3'd3, 32'h00310023, 1'b0, CW_STORE},                             // SB
	'{3'd3, 32'h00311023, 1'b0, CW_STORE | CW_SIZE_HALF},              // SH
	'{3'd3, 32'h00312023, 1'b0, CW_STORE | CW_SIZE_WORD},              // SW
	'{3'd3, 32'h00510093, 1'b0, CW_OPIMM | CW_ALU_ADD},                // ADDI
	'{3'd3, 32'h00512093, 1'b0, CW_OPIMM | CW_COND_NEG | CW_SLT},      // SLTI
	'{3'd3, 32'h00513093, 1'b0, CW_OPIMM | CW_SLTU},                   // SLTIU
	'{3'd3, 32'h00514093, 1'b0, CW_OPIMM | CW_XOR},                    // XORI
	'{3'd3, 32'h00516093, 1'b0, CW_OPIMM | CW_OR},                     // ORI
	'{3'd3, 32'h00517093, 1'b0, CW_OPIMM | CW_AND},                    // ANDI
	'{3'd3, 32'h00311093, 1'b0, CW_OPIMM | CW_SHIFT_LL},               // SLLI
	'{3'd3, 32'h00315093, 1'b0, CW_OPIMM | CW_SHIFT_RL},               // SRLI
	'{3'd3, 32'h40315093, 1'b0, CW_OPIMM | CW_SHIFT_RA},               // SRAI
	'{3'd3, 32'h003100B3, 1'b0, CW_OPREG | CW_ALU_ADD},                // ADD
	'{3'd3, 32'h403100B3, 1'b0, CW_OPREG | CW_ALU_SUB},                // SUB
	'{3'd3, 32'h003110B3, 1'b0, CW_OPREG | CW_SHIFT_LL},               // SLL
	'{3'd3, 32'h003120B3, 1'b0, CW_OPREG | CW_COND_NEG | CW_SLT},      // SLT
	'{3'd3, 32'h003130B3, 1'b0, CW_OPREG | CW_SLTU},                   // SLTU
	'{3'd3, 32'h003140B3, 1'b0, CW_OPREG | CW_XOR},                    // XOR
	'{3'd3, 32'h003150B3, 1'b0, CW_OPREG | CW_SHIFT_RL},               // SRL
	'{3'd3, 32'h403150B3, 1'b0, CW_OPREG | CW_SHIFT_RA},               // SRA
	'{3'd3, 32'h003160B3, 1'b0, CW_OPREG | CW_OR},                     // OR
	'{3'd3, 32'h003170B3, 1'b0, CW_OPREG | CW_AND},                    // AND
	'{3'd3, 32'h123450B7, 1'b0, CW_S1_PC | CW_S2_UPPER | CW_REG_WR},   // LUI
	'{3'd3, 32'h12345097, 1'b0, CW_S1_PC | CW_S2_UPPER | CW_ADD_PC | CW_REG_WR},
	'{3'd4, 32'h00310463, 1'b0, CW_BRANCH | CW_COND_ZERO},             // BEQ
	'{3'd4, 32'h00311463, 1'b0, CW_BRANCH | CW_COND_ZERO | CW_COND_INV},
	'{3'd4, 32'h00314463, 1'b0, CW_BRANCH | CW_COND_NEG},              // BLT
	'{3'd4, 32'h00315463, 1'b0, CW_BRANCH | CW_COND_NEG | CW_COND_INV},
	'{3'd4, 32'h00316463, 1'b0, CW_BRANCH | CW_COND_NEG | CW_UNSIGNED},
	'{3'd4, 32'h00317463, 1'b0, CW_BRANCH | CW_COND_NEG | CW_COND_INV | CW_UNSIGNED},
	'{3'd4, 32'h010000EF, 1'b0, CW_SRC_NONE | CW_S2_IMM20 | CW_BJU_JAL | CW_REG_WR},
	'{3'd4, 32'h000100E7, 1'b0, CW_SRC_RS12 | CW_S2_IMM12 | CW_BJU_JALR | CW_REG_WR},
	'{3'd4, 32'h300110F3, 1'b0, CW_CSR | CW_OP_RW},                    // CSRRW
	'{3'd4, 32'h300120F3, 1'b0, CW_CSR | CW_OP_RS},                    // CSRRS
	'{3'd4, 32'h300130F3, 1'b0, CW_CSR | CW_OP_RC},                    // CSRRC
	'{3'd4, 32'h3002D0F3, 1'b0, CW_CSR | CW_OP_RW | CW_CSR_IMM},       // CSRRWI
	'{3'd4, 32'h3002E0F3, 1'b0, CW_CSR | CW_OP_RS | CW_CSR_IMM},       // CSRRSI
	'{3'd4, 32'h3002F0F3, 1'b0, CW_CSR | CW_OP_RC | CW_CSR_IMM},       // CSRRCI
	'{3'd4, 32'h00000073, 1'b0, CW_ECALL},
	'{3'd4, 32'h30200073, 1'b0, CW_MRET},
	'{3'd4, 32'h00100073, 1'b0, 33'h0},                                // EBREAK, no priv op
	'{3'd5, 32'h0000000F, 1'b1, 33'h0},                                // FENCE
	'{3'd5, 32'h00010082, 1'b1, 33'h0},                                // Low opcode bits 10
	'{3'd5, 32'h023100B3, 1'b1, 33'h0},                                // ADD with funct7 01
	'{3'd5, 32'h00013083, 1'b1, 33'h0},                                // Load funct3 3
	'{3'd5, 32'h02315093, 1'b1, 33'h0},                                // SRLI with funct7 01
	'{3'd5, 32'h40311093, 1'b1, 33'h0}                                 // SLLI with alt funct7
};

`endif

// File: sim/urom_decode_tb.sv
`timescale 1ns/10ps
`include "urom_cfg.svh"

module urom_decode_tb import urom_cw_pkg::*; ();

	`include "urom_vectors.svh"

	localparam int RESET_CYCLES   = 16;
	localparam int BURST_LEN      = 4;
	localparam int MAX_GAP        = 3;
	localparam int NUM_TESTS      = 5;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * (MAX_GAP + 2) + 20 * NUM_TESTS;

	logic                    clk_i         = 1'b0;
	logic                    rst_n_i       = 1'b0;
	logic                    instr_valid_i = 1'b0;
	logic [`URM_INSTR_W-1:0] instr_i       = '0;
	dec_control_word_t       cw_o;
	logic                    cw_valid_o;
	logic                    invalid_o;

	int cycle      = 0;
	int pass_count = 0;
	int fail_count = 0;
	int test_start = 0;
	int got_row;
	int got_due;
	int row_q [$]; // Rows in flight, oldest first
	int due_q [$]; // Cycle each result is due
	bit seen [NUM_ROWS];
	bit checking   = 1'b0;

	urom_decode_top urom_decode_top_i (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.cw_o          (cw_o),
		.cw_valid_o    (cw_valid_o),
		.invalid_o     (invalid_o)
	);

	always #20 clk_i = ~clk_i;

	always @(posedge clk_i) cycle <= cycle + 1;

	task automatic check_value(input string name, input logic [32:0] exp, input logic [32:0] act);
		assert (act === exp) pass_count++;
		else begin
			$display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
			fail_count++;
		end
	endtask

	task automatic check_idle_outputs();
		check_value("cw_valid_o", 33'h0, cw_valid_o);
		check_value("invalid_o", 33'h0, invalid_o);
		check_value("cw_o", 33'h0, cw_o);
	endtask

	task automatic drive_row(input int idx);
		@(posedge clk_i);
		instr_valid_i <= 1'b1;
		instr_i       <= vectors[idx].instr;
		row_q.push_back(idx);
		due_q.push_back(cycle + 3); // Drive edge, decoder edge, table edge
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_i);
			instr_valid_i <= 1'b0;
		end
	endtask

	task automatic report_test(input int num, input string name);
		while (row_q.size() != 0) idle(1);
		$display("Test %0d %s: %s with %0d failures", num, name,
			(fail_count == test_start) ? "pass" : "fail", fail_count - test_start);
		test_start = fail_count;
	endtask

	// Results are sampled half a cycle after the table updates
	always @(negedge clk_i) begin
		if (checking && cw_valid_o) begin
			if (row_q.size() == 0) begin
				$display("At %0t ns cw_valid_o pulsed with nothing in flight", $time);
				fail_count++;
			end else begin
				got_row = row_q.pop_front();
				got_due = due_q.pop_front();
				check_value("cw_valid_o cycle", got_due, cycle);
				check_value("invalid_o", vectors[got_row].inval, invalid_o);
				check_value("cw_o", vectors[got_row].cw, cw_o);
				seen[got_row] = 1'b1;
			end
		end else if (checking && row_q.size() != 0 && due_q[0] <= cycle) begin
			$display("At %0t ns the result for row %0d did not arrive", $time, row_q[0]);
			fail_count++;
			void'(row_q.pop_front());
			void'(due_q.pop_front());
		end
	end

	initial begin
		wait (cycle >= TIMEOUT_CYCLES);
		$display("Run stopped after %0d cycles without finishing", cycle);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(33390));

		repeat (RESET_CYCLES) begin
			@(negedge clk_i);
			check_idle_outputs();
		end
		@(posedge clk_i);
		rst_n_i <= 1'b1;
		repeat (2) begin
			@(negedge clk_i);
			check_idle_outputs(); // Nothing strobed yet
		end
		checking = 1'b1;
		report_test(1, "reset");

		for (int i = 0; i < BURST_LEN; i++) drive_row(i);
		report_test(2, "latency");

		for (int i = 0; i < NUM_ROWS; i++) begin
			if (vectors[i].test == 3'd3) drive_row(i);
		end
		report_test(3, "memory and ALU");

		for (int i = 0; i < NUM_ROWS; i++) begin
			if (vectors[i].test == 3'd4) drive_row(i);
		end
		report_test(4, "control flow and system");

		for (int i = 0; i < NUM_ROWS; i++) begin
			if (vectors[i].test == 3'd5) begin
				drive_row(i);
				idle($urandom % (MAX_GAP + 1));
			end
		end
		report_test(5, "invalid");

		for (int i = 0; i < NUM_ROWS; i++) begin
			if (!seen[i]) begin
				$display("Row %0d, instruction %h, never produced a result", i, vectors[i].instr);
				fail_count++;
			end
		end
		$display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: hdl/urom_decode_top.sv
`timescale 1ns/10ps
`include "urom_cfg.svh"

module urom_decode_top import rv_isa_pkg::*, urom_cw_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    instr_valid_i,
	input  logic [`URM_INSTR_W-1:0] instr_i,
	output dec_control_word_t       cw_o,
	output logic                    cw_valid_o,
	output logic                    invalid_o
);

	urom_addr_t urom_addr; // Stage 1 to stage 2

	urom_field_decoder decoder_i (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.addr_o        (urom_addr)
	);

	urom_table table_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.addr_i     (urom_addr),
		.cw_o       (cw_o),
		.cw_valid_o (cw_valid_o),
		.invalid_o  (invalid_o)
	);

endmodule

// File: hdl/urom_table.sv
`timescale 1ns/10ps
`include "urom_cfg.svh"

module urom_table import rv_isa_pkg::*, urom_cw_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  urom_addr_t        addr_i,
	output dec_control_word_t cw_o,
	output logic              cw_valid_o,
	output logic              invalid_o
);

	dec_control_word_t cw_d;
	dec_control_word_t cw_q;
	logic [3:0]        minor_alt;
	logic              hit;
	logic              bad;
	logic              cw_valid_q;
	logic              invalid_q;

	assign minor_alt = {addr_i.minor, addr_i.alt};

	// Each major sets its shared fields, then the minor refines them
	always_comb begin
		cw_d = '0;
		hit  = 1'b1;
		case (addr_i.major)
			MAJOR_LOAD: begin
				cw_d.dec_src2_select = 2'b01;
				cw_d.exe_alu_add_en  = 1'b1; // Address adder
				cw_d.exe_reg_wr_en   = 1'b1;
				cw_d.exe_mem_op      = MEM_LOAD_OP;
				cw_d.exe_mem_op_en   = 1'b1;
				case (minor_alt)
					{MINOR_LB, 1'b0}: cw_d.exe_mem_op_size = MEM_SIZE_BYTE;
					{MINOR_LH, 1'b0}: cw_d.exe_mem_op_size = MEM_SIZE_HALF;
					{MINOR_LW, 1'b0}: cw_d.exe_mem_op_size = MEM_SIZE_WORD;
					{MINOR_LBU, 1'b0}: begin
						cw_d.exe_mem_op_size  = MEM_SIZE_BYTE;
						cw_d.dec_not_sign_ext = 1'b1;
					end
					{MINOR_LHU, 1'b0}: begin
						cw_d.exe_mem_op_size  = MEM_SIZE_HALF;
						cw_d.dec_not_sign_ext = 1'b1;
					end
					default: hit = 1'b0;
				endcase
			end
			MAJOR_STORE: begin
				cw_d.src_reg_used  = 2'b01;
				cw_d.exe_mem_op    = MEM_STORE_OP;
				cw_d.exe_mem_op_en = 1'b1;
				case (minor_alt)
					{MINOR_SB, 1'b0}: cw_d.exe_mem_op_size = MEM_SIZE_BYTE;
					{MINOR_SH, 1'b0}: cw_d.exe_mem_op_size = MEM_SIZE_HALF;
					{MINOR_SW, 1'b0}: cw_d.exe_mem_op_size = MEM_SIZE_WORD;
					default: hit = 1'b0;
				endcase
			end
			MAJOR_IMM, MAJOR_REG: begin
				if (addr_i.major == MAJOR_REG) begin
					cw_d.src_reg_used = 2'b01;
				end else begin
					cw_d.dec_src2_select = 2'b01;
				end
				cw_d.exe_reg_wr_en = 1'b1;
				case (minor_alt)
					{MINOR_ADD, 1'b0}: cw_d.exe_alu_add_en = 1'b1;
					{MINOR_ADD, 1'b1}: begin
						cw_d.exe_alu_sub_en = 1'b1;
						hit = (addr_i.major == MAJOR_REG); // No SUBI in RV32I
					end
					{MINOR_SLL, 1'b0}: cw_d.exe_shu_shift_en = SHIFT_LL;
					{MINOR_SLT, 1'b0}: begin
						cw_d.exe_condition_sel = COND_NEG;
						cw_d.exe_slt_en        = 1'b1;
					end
					{MINOR_SLTU, 1'b0}: begin
						cw_d.exe_condition_sel     = COND_NEG;
						cw_d.exe_alu_unsigned_n_en = 1'b1;
						cw_d.exe_slt_en            = 1'b1;
						cw_d.dec_not_sign_ext      = 1'b1;
					end
					{MINOR_XOR, 1'b0}: cw_d.exe_alu_logic_en = LOGIC_XOR;
					{MINOR_SRL, 1'b0}: cw_d.exe_shu_shift_en = SHIFT_RL;
					{MINOR_SRL, 1'b1}: cw_d.exe_shu_shift_en = SHIFT_RA;
					{MINOR_OR, 1'b0}:  cw_d.exe_alu_logic_en = LOGIC_OR;
					{MINOR_AND, 1'b0}: cw_d.exe_alu_logic_en = LOGIC_AND;
					default: hit = 1'b0;
				endcase
			end
			MAJOR_LUI, MAJOR_AUIPC: begin
				cw_d.dec_src1_select      = 2'b01;
				cw_d.dec_src2_select      = 2'b11;
				cw_d.exe_add_pc_to_res_en = (addr_i.major == MAJOR_AUIPC);
				cw_d.exe_reg_wr_en        = 1'b1;
				hit = (minor_alt == {F3_0, 1'b0});
			end
			MAJOR_BRANCH: begin
				cw_d.src_reg_used = 2'b01;
				cw_d.exe_bju_en   = BJU_BRANCH;
				case (minor_alt)
					{MINOR_BEQ, 1'b0}: cw_d.exe_condition_sel = COND_ZERO;
					{MINOR_BNE, 1'b0}: begin
						cw_d.exe_condition_sel = COND_ZERO;
						cw_d.exe_condition_neg = 1'b1;
					end
					{MINOR_BLT, 1'b0}: cw_d.exe_condition_sel = COND_NEG;
					{MINOR_BGE, 1'b0}: begin
						cw_d.exe_condition_sel = COND_NEG;
						cw_d.exe_condition_neg = 1'b1;
					end
					{MINOR_BLTU, 1'b0}: begin
						cw_d.exe_condition_sel     = COND_NEG;
						cw_d.exe_alu_unsigned_n_en = 1'b1;
					end
					{MINOR_BGEU, 1'b0}: begin
						cw_d.exe_condition_sel     = COND_NEG;
						cw_d.exe_condition_neg     = 1'b1;
						cw_d.exe_alu_unsigned_n_en = 1'b1;
					end
					default: hit = 1'b0;
				endcase
			end
			MAJOR_JALR: begin
				cw_d.src_reg_used    = 2'b01;
				cw_d.dec_src2_select = 2'b01;
				cw_d.exe_bju_en      = BJU_JALR;
				cw_d.exe_reg_wr_en   = 1'b1;
				hit = (minor_alt == {F3_0, 1'b0});
			end
			MAJOR_JAL: begin
				cw_d.src_reg_used    = 2'b10; // No register source
				cw_d.dec_src2_select = 2'b10;
				cw_d.exe_bju_en      = BJU_JAL;
				cw_d.exe_reg_wr_en   = 1'b1;
				hit = (minor_alt == {F3_0, 1'b0});
			end
			MAJOR_SYSTEM: begin
				if (minor_alt == {MINOR_PRIV, 1'b0}) begin
					case (addr_i.sub_addr)
						`URM_SUB_ECALL: cw_d.exe_sys_priv_en = PRIV_ECALL;
						`URM_SUB_MRET:  cw_d.exe_sys_priv_en = PRIV_MRET;
						default:        cw_d.exe_sys_priv_en = PRIV_NONE;
					endcase
				end else begin
					cw_d.exe_csr_en      = 1'b1;
					cw_d.dec_src2_select = 2'b01;
					cw_d.exe_reg_wr_en   = 1'b1;
					cw_d.dec_csr_imm     = addr_i.minor[2]; // Upper half is the zimm forms
					case (minor_alt)
						{MINOR_CSRRW, 1'b0}, {MINOR_CSRRWI, 1'b0}: cw_d.exe_csr_op = CSR_RW;
						{MINOR_CSRRS, 1'b0}, {MINOR_CSRRSI, 1'b0}: cw_d.exe_csr_op = CSR_RS;
						{MINOR_CSRRC, 1'b0}, {MINOR_CSRRCI, 1'b0}: cw_d.exe_csr_op = CSR_RC;
						default: hit = 1'b0;
					endcase
				end
			end
			default: hit = 1'b0;
		endcase
	end

	assign bad = addr_i.illegal || !hit;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cw_q       <= '0;
			cw_valid_q <= 1'b0;
			invalid_q  <= 1'b0;
		end else begin
			cw_valid_q <= addr_i.valid;
			if (addr_i.valid) begin
				cw_q      <= bad ? '0 : cw_d; // Rejected words go out as zero
				invalid_q <= bad;
			end
		end
	end

	assign cw_o       = cw_q;
	assign cw_valid_o = cw_valid_q;
	assign invalid_o  = invalid_q;

endmodule

// File: hdl/urom_field_decoder.sv
`timescale 1ns/10ps
`include "urom_cfg.svh"

module urom_field_decoder import rv_isa_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    instr_valid_i,
	input  logic [`URM_INSTR_W-1:0] instr_i,
	output urom_addr_t              addr_o
);

	rv_instr_t  fields;
	rv_minor_e  minor;
	logic       quad_ok;
	logic       major_known;
	logic       shift_imm;
	logic       funct7_checked;
	logic       alt_ok;
	logic       alt_bit;
	logic       funct7_bad;
	logic       illegal;
	urom_addr_t addr_q;

	assign fields  = rv_instr_t'(instr_i);
	assign quad_ok = (fields.quad == 2'b11); // RV32I has no compressed forms here

	// funct7 is only an opcode field for R-type and shift immediates
	assign shift_imm = (fields.major == MAJOR_IMM) &&
		((fields.funct3 == MINOR_SLL) || (fields.funct3 == MINOR_SRL));
	assign funct7_checked = (fields.major == MAJOR_REG) || shift_imm;

	// SUB, SRA and SRAI
	assign alt_ok = ((fields.major == MAJOR_REG) && (fields.funct3 == MINOR_ADD)) ||
		(funct7_checked && (fields.funct3 == MINOR_SRL));
	assign alt_bit    = alt_ok && (fields.funct7 == `URM_FUNCT7_ALT);
	assign funct7_bad = funct7_checked && (fields.funct7 != '0) && !alt_bit;

	always_comb begin
		case (fields.major)
			MAJOR_LOAD, MAJOR_IMM, MAJOR_AUIPC, MAJOR_STORE, MAJOR_REG,
			MAJOR_LUI, MAJOR_BRANCH, MAJOR_JALR, MAJOR_JAL, MAJOR_SYSTEM: begin
				major_known = 1'b1;
			end
			default: major_known = 1'b0;
		endcase
	end

	// U and J formats carry immediate bits in funct3
	always_comb begin
		case (fields.major)
			MAJOR_LUI, MAJOR_AUIPC, MAJOR_JAL: minor = F3_0;
			default: minor = fields.funct3;
		endcase
	end

	assign illegal = !quad_ok || !major_known || funct7_bad;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			addr_q <= '0;
		end else begin
			addr_q.valid <= instr_valid_i;
			if (instr_valid_i) begin // Hold last address when idle
				addr_q.major    <= fields.major;
				addr_q.minor    <= minor;
				addr_q.alt      <= alt_bit;
				addr_q.sub_addr <= fields.rs2;
				addr_q.illegal  <= illegal;
			end
		end
	end

	assign addr_o = addr_q;

endmodule

// File: hdl/urom_cw_pkg.sv
package urom_cw_pkg;

	typedef enum logic [1:0] {
		MEM_SIZE_BYTE = 2'b00,
		MEM_SIZE_HALF = 2'b01,
		MEM_SIZE_WORD = 2'b10
	} mem_size_e;

	typedef enum logic {
		MEM_LOAD_OP  = 1'b0,
		MEM_STORE_OP = 1'b1
	} mem_op_e;

	typedef enum logic [2:0] {
		CSR_NOP = 3'b000,
		CSR_RS  = 3'b101,
		CSR_RC  = 3'b110,
		CSR_RW  = 3'b111
	} csr_op_e;

	typedef enum logic [1:0] {LOGIC_NONE, LOGIC_AND, LOGIC_OR, LOGIC_XOR} logic_op_e;
	typedef enum logic [1:0] {SHIFT_NONE, SHIFT_LL, SHIFT_RL, SHIFT_RA} shift_op_e;
	typedef enum logic [1:0] {COND_NONE, COND_NEG, COND_ZERO} cond_sel_e; // ALU flag picked
	typedef enum logic [1:0] {BJU_NONE, BJU_BRANCH, BJU_JAL, BJU_JALR} bju_op_e;
	typedef enum logic [1:0] {PRIV_NONE, PRIV_ECALL, PRIV_MRET} priv_op_e;

	typedef struct packed {
		logic [1:0] src_reg_used;    // 00 rs1, 01 rs1 and rs2, 10 none
		logic [1:0] dec_src1_select; // 00 reg, 01 PC or zero
		logic [1:0] dec_src2_select; // 00 reg, 01 imm12, 10 imm20, 11 upper imm
		logic       dec_not_sign_ext;
		logic       dec_csr_imm;
		logic       exe_alu_add_en;
		logic       exe_alu_sub_en;
		logic_op_e  exe_alu_logic_en;
		logic       exe_alu_unsigned_n_en;
		shift_op_e  exe_shu_shift_en;
		cond_sel_e  exe_condition_sel;
		logic       exe_condition_neg;
		logic       exe_slt_en;
		logic       exe_add_pc_to_res_en;
		bju_op_e    exe_bju_en;
		logic       exe_reg_wr_en;
		mem_op_e    exe_mem_op;
		mem_size_e  exe_mem_op_size;
		logic       exe_mem_op_en;
		logic       exe_csr_en;
		csr_op_e    exe_csr_op;
		priv_op_e   exe_sys_priv_en;
	} dec_control_word_t;

endpackage

// File: hdl/rv_isa_pkg.sv
`include "urom_cfg.svh"

package rv_isa_pkg;

	// Opcode bits 6 to 2
	typedef enum logic [`URM_MAJOR_W-1:0] {
		MAJOR_LOAD   = 5'b00000,
		MAJOR_IMM    = 5'b00100,
		MAJOR_AUIPC  = 5'b00101,
		MAJOR_STORE  = 5'b01000,
		MAJOR_REG    = 5'b01100,
		MAJOR_LUI    = 5'b01101,
		MAJOR_BRANCH = 5'b11000,
		MAJOR_JALR   = 5'b11001,
		MAJOR_JAL    = 5'b11011,
		MAJOR_SYSTEM = 5'b11100
	} rv_major_e;

	// Raw funct3 codes, meaning depends on the major
	typedef enum logic [`URM_MINOR_W-1:0] {
		F3_0, F3_1, F3_2, F3_3, F3_4, F3_5, F3_6, F3_7
	} rv_minor_e;

	// Loads and stores
	localparam rv_minor_e MINOR_LB  = F3_0;
	localparam rv_minor_e MINOR_LH  = F3_1;
	localparam rv_minor_e MINOR_LW  = F3_2;
	localparam rv_minor_e MINOR_LBU = F3_4;
	localparam rv_minor_e MINOR_LHU = F3_5;
	localparam rv_minor_e MINOR_SB  = F3_0;
	localparam rv_minor_e MINOR_SH  = F3_1;
	localparam rv_minor_e MINOR_SW  = F3_2;

	// ALU, shared by register and immediate forms
	localparam rv_minor_e MINOR_ADD  = F3_0; // Also SUB with alt
	localparam rv_minor_e MINOR_SLL  = F3_1;
	localparam rv_minor_e MINOR_SLT  = F3_2;
	localparam rv_minor_e MINOR_SLTU = F3_3;
	localparam rv_minor_e MINOR_XOR  = F3_4;
	localparam rv_minor_e MINOR_SRL  = F3_5; // Also SRA with alt
	localparam rv_minor_e MINOR_OR   = F3_6;
	localparam rv_minor_e MINOR_AND  = F3_7;

	// Branches
	localparam rv_minor_e MINOR_BEQ  = F3_0;
	localparam rv_minor_e MINOR_BNE  = F3_1;
	localparam rv_minor_e MINOR_BLT  = F3_4;
	localparam rv_minor_e MINOR_BGE  = F3_5;
	localparam rv_minor_e MINOR_BLTU = F3_6;
	localparam rv_minor_e MINOR_BGEU = F3_7;

	// System
	localparam rv_minor_e MINOR_PRIV   = F3_0;
	localparam rv_minor_e MINOR_CSRRW  = F3_1;
	localparam rv_minor_e MINOR_CSRRS  = F3_2;
	localparam rv_minor_e MINOR_CSRRC  = F3_3;
	localparam rv_minor_e MINOR_CSRRWI = F3_5;
	localparam rv_minor_e MINOR_CSRRSI = F3_6;
	localparam rv_minor_e MINOR_CSRRCI = F3_7;

	// R-type view of the instruction word, MSB first
	typedef struct packed {
		logic [`URM_FUNCT7_W-1:0] funct7;
		logic [`URM_REG_W-1:0]    rs2;
		logic [`URM_REG_W-1:0]    rs1;
		rv_minor_e                funct3;
		logic [`URM_REG_W-1:0]    rd;
		rv_major_e                major;
		logic [`URM_QUAD_W-1:0]   quad;
	} rv_instr_t;

	// Micro-ROM address bundle between the two stages
	typedef struct packed {
		rv_major_e                  major;
		rv_minor_e                  minor;
		logic                       alt;
		logic [`URM_SUBADDR_W-1:0]  sub_addr;
		logic                       illegal;
		logic                       valid;
	} urom_addr_t;

endpackage

// File: hdl/urom_cfg.svh
`ifndef UROM_CFG_SVH
`define UROM_CFG_SVH

// Instruction word
`define URM_INSTR_W     32

// Field widths, LSB to MSB: quad, major, rd, funct3, rs1, rs2, funct7
`define URM_QUAD_W      2
`define URM_MAJOR_W     5
`define URM_REG_W       5
`define URM_MINOR_W     3
`define URM_FUNCT7_W    7

// funct7 of SUB, SRA and SRAI
`define URM_FUNCT7_ALT  7'b0100000

// System sub-address, taken from bits 24 to 20
`define URM_SUBADDR_W   5
`define URM_SUB_ECALL   5'd0
`define URM_SUB_MRET    5'd2

`endif
